/* common/life_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// life core shared definitions
// grid and raster constants, bridge address map, reset pattern
// and the packed types that travel between blocks
////////////////////////////////////////////////////////////////////////////

package life_pkg;

    // board geometry in cells, cell edge in pixels
    localparam int GRID_W  = 64;
    localparam int GRID_H  = 48;
    localparam int CELL_PX = 10;

    // raster timing, counts start at the back porch
    localparam int H_BPORCH = 160;
    localparam int H_ACTIVE = 640;
    localparam int H_TOTAL  = 800;
    localparam int V_BPORCH = 20;
    localparam int V_ACTIVE = 480;
    localparam int V_TOTAL  = 500;
    localparam int HS_X     = 3;

    // generation rate accumulator
    localparam int unsigned GEN_PERIOD      = 25_000_000;
    localparam int unsigned GEN_SPEED_RESET = 1;

    // bridge register map
    localparam logic [31:0] ADDR_GEN_SPEED = 32'h0010_0000;
    localparam logic [31:0] ADDR_CTRL      = 32'h0010_0004;
    localparam logic [31:0] ADDR_GEN_COUNT = 32'h0010_0008;

    // row r word w sits at base + r*8 + w*4
    localparam logic [31:0] SEED_BASE  = 32'h0020_0000;
    localparam logic [31:0] BOARD_BASE = 32'h0030_0000;

    // control register bits
    localparam int CTRL_RUN  = 0;
    localparam int CTRL_LOAD = 1;
    localparam int CTRL_STEP = 2;

    // row-major, cell (r, c) at bit r*GRID_W + c
    typedef logic [GRID_W*GRID_H-1:0] board_t;

    // start pattern on rows 22 to 24
    localparam board_t PRESET = board_t'({64'h0000_0006_4000_0000,
                                          64'h0000_0004_4000_0000,
                                          64'h0000_0004_C000_0000}) << (22 * GRID_W);

    typedef struct packed {
        logic [31:0] addr;
        logic        rd;
        logic        wr;
        logic [31:0] wr_data;
    } bridge_req_t;

    // x and y are relative to the active window
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        logic       de;
        logic       hs;
        logic       vs;
    } vid_pos_t;

    typedef struct packed {
        logic load;
        logic step;
        logic run;
    } board_cmd_t;

endpackage

/* life/life_cell.sv */
////////////////////////////////////////////////////////////////////////////
// one life cell, neighbour count and survival/birth rule
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module life_cell (
    input  logic       clk_74a,
    input  logic       reset_n,
    input  logic [7:0] neighbours,
    input  logic       tick,
    input  logic       load,
    input  logic       seed_bit,
    input  logic       preset_bit,
    output logic       alive
);

    logic [3:0] population;
    logic       next_state;

    always_comb begin
        population = '0;
        for (int i = 0; i < 8; i++) begin
            population = population + 4'(neighbours[i]);
        end
    end

    // born on three, survives on two or three
    assign next_state = (population == 4'd3) || (population == 4'd2 && alive);

    // load wins over a tick on the same edge
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            alive <= preset_bit;
        end else if (load) begin
            alive <= seed_bit;
        end else if (tick) begin
            alive <= next_state;
        end
    end

endmodule

/* life/life_board.sv */
////////////////////////////////////////////////////////////////////////////
// life board
// grid of cells wired as a torus, plus the generation counter
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module life_board #(
    parameter int GRID_W = life_pkg::GRID_W,
    parameter int GRID_H = life_pkg::GRID_H
) (
    input  logic             clk_74a,
    input  logic             reset_n,
    input  logic             tick,
    input  logic             load,
    input  life_pkg::board_t seed,
    output life_pkg::board_t board,
    output logic [15:0]      gen_count
);

    import life_pkg::*;

    wire [GRID_W*GRID_H-1:0] cells;

    for (genvar r = 0; r < GRID_H; r++) begin : g_row
        for (genvar c = 0; c < GRID_W; c++) begin : g_col
            // neighbour rows and columns wrap at the edges
            localparam int UP = (r + GRID_H - 1) % GRID_H;
            localparam int DN = (r + 1) % GRID_H;
            localparam int LF = (c + GRID_W - 1) % GRID_W;
            localparam int RT = (c + 1) % GRID_W;

            logic [7:0] neighbours;

            assign neighbours = {cells[UP*GRID_W + LF], cells[UP*GRID_W + c],
                                 cells[UP*GRID_W + RT], cells[r*GRID_W + LF],
                                 cells[r*GRID_W + RT],  cells[DN*GRID_W + LF],
                                 cells[DN*GRID_W + c],  cells[DN*GRID_W + RT]};

            life_cell u_cell (
                .clk_74a    (clk_74a),
                .reset_n    (reset_n),
                .neighbours (neighbours),
                .tick       (tick),
                .load       (load),
                .seed_bit   (seed[r*GRID_W + c]),
                .preset_bit (PRESET[r*GRID_W + c]),
                .alive      (cells[r*GRID_W + c])
            );
        end
    end

    assign board = cells;

    // counts ticks only, a load leaves it alone
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            gen_count <= '0;
        end else if (tick) begin
            gen_count <= gen_count + 16'd1;
        end
    end

endmodule

/* life/gen_ticker.sv */
////////////////////////////////////////////////////////////////////////////
// generation ticker
// adds the speed each cycle while running, ticks on overflow or step
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module gen_ticker #(
    parameter int unsigned GEN_PERIOD = life_pkg::GEN_PERIOD
) (
    input  logic        clk_74a,
    input  logic        reset_n,
    input  logic        run,
    input  logic        step,
    input  logic [31:0] gen_speed,
    output logic        tick
);

    logic [31:0] accum;
    logic [32:0] sum;
    logic        overflow;

    // one spare bit so a large speed cannot wrap the compare
    assign sum      = {1'b0, accum} + {1'b0, gen_speed};
    assign overflow = run && (sum >= 33'(GEN_PERIOD));

    // keep the remainder so the average rate follows the speed
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            accum <= '0;
        end else if (run) begin
            if (overflow) begin
                accum <= 32'(sum - 33'(GEN_PERIOD));
            end else begin
                accum <= sum[31:0];
            end
        end
    end

    assign tick = overflow | step;

endmodule

/* video/video_timing.sv */
////////////////////////////////////////////////////////////////////////////
// video timing generator
// 800 x 500 raster with a 640 x 480 active window, registered position
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module video_timing (
    input  logic               clk_74a,
    input  logic               reset_n,
    output life_pkg::vid_pos_t pos
);

    import life_pkg::*;

    // counter width matches the position fields
    logic [9:0] h_count;
    logic [9:0] v_count;
    logic       h_active;
    logic       v_active;

    assign h_active = (h_count >= 10'(H_BPORCH)) && (h_count < 10'(H_BPORCH + H_ACTIVE));
    assign v_active = (v_count >= 10'(V_BPORCH)) && (v_count < 10'(V_BPORCH + V_ACTIVE));

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            h_count <= '0;
            v_count <= '0;
        end else if (h_count == 10'(H_TOTAL - 1)) begin
            h_count <= '0;
            if (v_count == 10'(V_TOTAL - 1)) begin
                v_count <= '0;
            end else begin
                v_count <= v_count + 10'd1;
            end
        end else begin
            h_count <= h_count + 10'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // syncs and window position

    // hs lands a few clocks after vs, both inside the back porch
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            pos <= '0;
        end else begin
            pos.x  <= h_count - 10'(H_BPORCH);
            pos.y  <= v_count - 10'(V_BPORCH);
            pos.de <= h_active && v_active;
            pos.hs <= (h_count == 10'(HS_X));
            pos.vs <= (h_count == 10'd0) && (v_count == 10'd0);
        end
    end

endmodule

/* video/pixel_renderer.sv */
////////////////////////////////////////////////////////////////////////////
// pixel renderer
// one cell per CELL_PX square, white when live, syncs kept aligned
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module pixel_renderer #(
    parameter int GRID_W  = life_pkg::GRID_W,
    parameter int GRID_H  = life_pkg::GRID_H,
    parameter int CELL_PX = life_pkg::CELL_PX
) (
    input  logic               clk_74a,
    input  logic               reset_n,
    input  life_pkg::vid_pos_t pos,
    input  life_pkg::board_t   board,
    output logic [23:0]        video_rgb,
    output logic               video_de,
    output logic               video_hs,
    output logic               video_vs
);

    localparam int IDX_W = $clog2(GRID_W * GRID_H);

    logic [9:0]       cell_x;
    logic [9:0]       cell_y;
    logic [IDX_W-1:0] cell_idx;
    logic             live;

    assign cell_x   = pos.x / 10'(CELL_PX);
    assign cell_y   = pos.y / 10'(CELL_PX);
    assign cell_idx = IDX_W'(cell_y * GRID_W + cell_x);
    // outside the window the index is meaningless, de masks it
    assign live     = pos.de && board[cell_idx];

    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            video_rgb <= '0;
            video_de  <= 1'b0;
            video_hs  <= 1'b0;
            video_vs  <= 1'b0;
        end else begin
            video_rgb <= live ? 24'hFF_FFFF : 24'h00_0000;
            video_de  <= pos.de;
            video_hs  <= pos.hs;
            video_vs  <= pos.vs;
        end
    end

endmodule

/* design/bridge_regs.sv */
////////////////////////////////////////////////////////////////////////////
// bridge register block
// speed and run registers, seed memory, load and step pulses
// and a registered read mux over registers, seed and live board
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module bridge_regs #(
    parameter int GRID_W = life_pkg::GRID_W,
    parameter int GRID_H = life_pkg::GRID_H
) (
    input  logic                  clk_74a,
    input  logic                  reset_n,
    input  life_pkg::bridge_req_t bridge_req,
    input  life_pkg::board_t      board,
    input  logic [15:0]           gen_count,
    output logic [31:0]           bridge_rd_data,
    output life_pkg::board_cmd_t  cmd,
    output logic [31:0]           gen_speed,
    output life_pkg::board_t      seed
);

    import life_pkg::*;

    localparam int IDX_W = $clog2(GRID_W * GRID_H);
    localparam int ROW_W = $clog2(GRID_H);
    // each region spans eight bytes per row
    localparam logic [31:0] REGION_BYTES = 32'(GRID_H * 8);

    logic [31:0]      seed_off;
    logic [31:0]      board_off;
    logic             seed_hit;
    logic             board_hit;
    logic [IDX_W-1:0] seed_idx;
    logic [IDX_W-1:0] board_idx;
    logic [31:0]      rd_mux;

    // bit index of the word at a region offset
    function automatic logic [IDX_W-1:0] word_base(input logic [31:0] off);
        logic [IDX_W-1:0] row;
        row = IDX_W'(off[ROW_W+2:3]);
        return row * IDX_W'(GRID_W) + IDX_W'({off[2], 5'd0});
    endfunction

    // addresses below a base wrap high and miss
    assign seed_off  = bridge_req.addr - SEED_BASE;
    assign board_off = bridge_req.addr - BOARD_BASE;
    assign seed_hit  = seed_off < REGION_BYTES;
    assign board_hit = board_off < REGION_BYTES;
    assign seed_idx  = word_base(seed_off);
    assign board_idx = word_base(board_off);

    // speed, run and the one-cycle command pulses
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            gen_speed <= GEN_SPEED_RESET;
            cmd       <= '0;
        end else begin
            cmd.load <= 1'b0;
            cmd.step <= 1'b0;
            if (bridge_req.wr && bridge_req.addr == ADDR_GEN_SPEED) begin
                gen_speed <= bridge_req.wr_data;
            end
            if (bridge_req.wr && bridge_req.addr == ADDR_CTRL) begin
                cmd.run  <= bridge_req.wr_data[CTRL_RUN];
                cmd.load <= bridge_req.wr_data[CTRL_LOAD];
                cmd.step <= bridge_req.wr_data[CTRL_STEP];
            end
        end
    end

    // seed memory, one 32-bit word per write
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            seed <= PRESET;
        end else if (bridge_req.wr && seed_hit) begin
            seed[seed_idx +: 32] <= bridge_req.wr_data;
        end
    end

    always_comb begin
        rd_mux = '0;
        if (bridge_req.addr == ADDR_GEN_SPEED) begin
            rd_mux = gen_speed;
        end else if (bridge_req.addr == ADDR_CTRL) begin
            rd_mux[CTRL_RUN] = cmd.run;
        end else if (bridge_req.addr == ADDR_GEN_COUNT) begin
            rd_mux = {16'd0, gen_count};
        end else if (seed_hit) begin
            rd_mux = seed[seed_idx +: 32];
        end else if (board_hit) begin
            rd_mux = board[board_idx +: 32];
        end
    end

    // read data holds until the next read strobe
    always_ff @(posedge clk_74a or negedge reset_n) begin
        if (!reset_n) begin
            bridge_rd_data <= '0;
        end else if (bridge_req.rd) begin
            bridge_rd_data <= rd_mux;
        end
    end

endmodule

/* design/life_top.sv */
////////////////////////////////////////////////////////////////////////////
// life core top level
// bridge registers, generation ticker, cell board and video path
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module life_top #(
    parameter int          GRID_W     = life_pkg::GRID_W,
    parameter int          GRID_H     = life_pkg::GRID_H,
    parameter int          CELL_PX    = life_pkg::CELL_PX,
    parameter int unsigned GEN_PERIOD = life_pkg::GEN_PERIOD
) (
    input  logic                  clk_74a,
    input  logic                  reset_n,
    input  life_pkg::bridge_req_t bridge_req,
    output logic [31:0]           bridge_rd_data,
    output logic [23:0]           video_rgb,
    output logic                  video_de,
    output logic                  video_hs,
    output logic                  video_vs
);

    import life_pkg::*;

    board_cmd_t  cmd;
    logic [31:0] gen_speed;
    board_t      seed;
    board_t      board;
    logic [15:0] gen_count;
    logic        tick;
    vid_pos_t    pos;

    ////////////////////////////////////////////////////////////////////////
    // control and board

    bridge_regs #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) u_bridge_regs (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_req     (bridge_req),
        .board          (board),
        .gen_count      (gen_count),
        .bridge_rd_data (bridge_rd_data),
        .cmd            (cmd),
        .gen_speed      (gen_speed),
        .seed           (seed)
    );

    gen_ticker #(
        .GEN_PERIOD (GEN_PERIOD)
    ) u_gen_ticker (
        .clk_74a   (clk_74a),
        .reset_n   (reset_n),
        .run       (cmd.run),
        .step      (cmd.step),
        .gen_speed (gen_speed),
        .tick      (tick)
    );

    life_board #(
        .GRID_W (GRID_W),
        .GRID_H (GRID_H)
    ) u_life_board (
        .clk_74a   (clk_74a),
        .reset_n   (reset_n),
        .tick      (tick),
        .load      (cmd.load),
        .seed      (seed),
        .board     (board),
        .gen_count (gen_count)
    );

    ////////////////////////////////////////////////////////////////////////
    // video

    video_timing u_video_timing (
        .clk_74a (clk_74a),
        .reset_n (reset_n),
        .pos     (pos)
    );

    pixel_renderer #(
        .GRID_W  (GRID_W),
        .GRID_H  (GRID_H),
        .CELL_PX (CELL_PX)
    ) u_pixel_renderer (
        .clk_74a   (clk_74a),
        .reset_n   (reset_n),
        .pos       (pos),
        .board     (board),
        .video_rgb (video_rgb),
        .video_de  (video_de),
        .video_hs  (video_hs),
        .video_vs  (video_vs)
    );

endmodule

/* verification/life_tb.sv */
////////////////////////////////////////////////////////////////////////////
// life core testbench
// bridge access, toroidal reference model, step, run and frame checks
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module life_tb;

    import life_pkg::*;

    localparam int POLL_LIMIT  = 5000;
    localparam int FRAME_LIMIT = H_TOTAL * V_TOTAL + 16;

    logic        clk_74a;
    logic        reset_n;
    bridge_req_t bridge_req;
    logic [31:0] bridge_rd_data;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;

    bit          model [GRID_H][GRID_W];
    logic [31:0] seed_words [GRID_H][2];
    int          step_count;
    int          run_speed;
    int          run_min;
    logic [31:0] rng;
    logic [31:0] data;
    int          count_before;
    int          count_after;
    int          polls;

    life_top DUT (
        .clk_74a        (clk_74a),
        .reset_n        (reset_n),
        .bridge_req     (bridge_req),
        .bridge_rd_data (bridge_rd_data),
        .video_rgb      (video_rgb),
        .video_de       (video_de),
        .video_hs       (video_hs),
        .video_vs       (video_vs)
    );

    initial clk_74a = 1'b0;
    always #5 clk_74a = ~clk_74a;

    ////////////////////////////////////////////////////////////////////////
    // error handling and checks

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////
    // bridge access, one strobe cycle each

    task automatic bridge_write(input logic [31:0] addr, input logic [31:0] wdata);
        @(posedge clk_74a);
        bridge_req.addr    <= addr;
        bridge_req.wr_data <= wdata;
        bridge_req.wr      <= 1'b1;
        @(posedge clk_74a);
        bridge_req.wr      <= 1'b0;
    endtask

    // data is registered on the edge after the strobe
    task automatic bridge_read(input logic [31:0] addr, output logic [31:0] rdata);
        @(posedge clk_74a);
        bridge_req.addr <= addr;
        bridge_req.rd   <= 1'b1;
        @(posedge clk_74a);
        bridge_req.rd   <= 1'b0;
        @(negedge clk_74a);
        rdata = bridge_rd_data;
    endtask

    ////////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] model_word(input int r, input int w);
        logic [31:0] word;
        word = '0;
        for (int n = 0; n < 32; n++) begin
            word[n] = model[r][32 * w + n];
        end
        return word;
    endfunction

    task automatic model_from_seed();
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++) begin
                model[r][c] = seed_words[r][c / 32][c % 32];
            end
        end
    endtask

    // preset cells on rows 22 to 24
    task automatic model_preset();
        for (int r = 0; r < GRID_H; r++) begin
            for (int c = 0; c < GRID_W; c++) begin
                model[r][c] = 1'b0;
            end
        end
        model[22][30] = 1'b1;
        model[22][31] = 1'b1;
        model[22][34] = 1'b1;
        model[23][30] = 1'b1;
        model[23][34] = 1'b1;
        model[24][30] = 1'b1;
        model[24][33] = 1'b1;
        model[24][34] = 1'b1;
    endtask

    // neighbours wrap on both axes
    task automatic advance_model(input int gens);
        bit nxt [GRID_H][GRID_W];
        int n;
        for (int g = 0; g < gens; g++) begin
            for (int r = 0; r < GRID_H; r++) begin
                for (int c = 0; c < GRID_W; c++) begin
                    n = 0;
                    for (int dr = -1; dr <= 1; dr++) begin
                        for (int dc = -1; dc <= 1; dc++) begin
                            if (dr != 0 || dc != 0) begin
                                n += int'(model[(r + dr + GRID_H) % GRID_H]
                                               [(c + dc + GRID_W) % GRID_W]);
                            end
                        end
                    end
                    nxt[r][c] = (n == 3) || (n == 2 && model[r][c]);
                end
            end
            model = nxt;
        end
    endtask

    task automatic compare_board(input string what);
        logic [31:0] rdata;
        for (int r = 0; r < GRID_H; r++) begin
            for (int w = 0; w < 2; w++) begin
                bridge_read(BOARD_BASE + 32'(r * 8 + w * 4), rdata);
                check_value(rdata, model_word(r, w),
                            $sformatf("%s board row %0d word %0d", what, r, w));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // stimulus file

    task automatic read_stimulus();
        int          fd;
        int          items;
        int          r;
        int          w;
        logic [31:0] val;
        string       line;
        string       kw;
        for (int i = 0; i < GRID_H; i++) begin
            seed_words[i][0] = '0;
            seed_words[i][1] = '0;
        end
        step_count = -1;
        run_min    = -1;
        fd = $fopen("verification/life_stimulus.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open verification/life_stimulus.txt");
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;
            end
            items = $sscanf(line, "%s", kw);
            if (kw == "seed") begin
                items = $sscanf(line, "%s %d %d %h", kw, r, w, val);
                if (items != 4 || r < 0 || r >= GRID_H || w < 0 || w > 1) begin
                    stop_on_error("malformed seed line in the stimulus file");
                end
                seed_words[r][w] = val;
            end else if (kw == "steps") begin
                items = $sscanf(line, "%s %d", kw, step_count);
            end else if (kw == "run") begin
                items = $sscanf(line, "%s %d %d", kw, run_speed, run_min);
            end else begin
                stop_on_error("unknown keyword in the stimulus file");
            end
        end
        $fclose(fd);
        if (step_count < 0 || run_min < 0) begin
            stop_on_error("stimulus file lacks a steps or run line");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////
    // one frame from vs to vs, board frozen

    task automatic check_pixel(input int x, input int y);
        logic [31:0] expected;
        if (x >= H_ACTIVE || y >= V_ACTIVE) begin
            stop_on_error("video_de is active outside a 640 by 480 window");
        end
        expected = model[y / CELL_PX][x / CELL_PX] ? 32'h00FF_FFFF : 32'h0;
        check_value({8'd0, video_rgb}, expected, $sformatf("pixel x %0d y %0d", x, y));
    endtask

    task automatic check_frame();
        int   waited;
        int   cycles;
        int   de_count;
        int   hs_count;
        int   vs_count;
        int   x;
        int   y;
        int   gap;
        logic in_line;
        logic vs_prev;
        logic done;
        waited = 0;
        @(negedge clk_74a);
        while (!video_vs) begin
            if (waited == FRAME_LIMIT) begin
                stop_on_error("no vertical sync pulse seen within one frame time");
            end
            @(negedge clk_74a);
            waited++;
        end
        cycles   = 0;
        de_count = 0;
        hs_count = 0;
        vs_count = 0;
        x        = 0;
        y        = 0;
        gap      = 0;
        in_line  = 1'b0;
        vs_prev  = 1'b1;
        done     = 1'b0;
        while (!done) begin
            if (video_vs) begin
                vs_count++;
            end
            if (video_hs) begin
                hs_count++;
            end
            // x and y follow the de runs
            if (video_de) begin
                de_count++;
                if (gap == 0) begin
                    check_pixel(x, y);
                    rng = xorshift(rng);
                    gap = int'(rng[5:0]);
                end else begin
                    gap--;
                end
                x++;
                in_line = 1'b1;
            end else if (in_line) begin
                x = 0;
                y++;
                in_line = 1'b0;
            end
            vs_prev = video_vs;
            @(negedge clk_74a);
            cycles++;
            // frame ends where the next vs pulse begins
            if (video_vs && !vs_prev) begin
                done = 1'b1;
            end else if (cycles == FRAME_LIMIT) begin
                stop_on_error("second vertical sync pulse did not arrive");
            end
        end
        // last line runs right up to the next vs
        if (in_line) begin
            y++;
        end
        check_value(32'(de_count), 32'(H_ACTIVE * V_ACTIVE), "de cycles per frame");
        check_value(32'(y), 32'(V_ACTIVE), "active lines per frame");
        check_value(32'(hs_count), 32'(V_TOTAL), "hs pulses per frame");
        check_value(32'(vs_count), 32'd1, "vs pulses per frame");
    endtask

    ////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        reset_n    = 1'b0;
        bridge_req = '0;
        rng        = 32'h2a6;
        read_stimulus();
        model_preset();
        repeat (16) @(posedge clk_74a);
        reset_n <= 1'b1;

        // reset state
        bridge_read(ADDR_GEN_SPEED, data);
        check_value(data, GEN_SPEED_RESET, "speed after reset");
        bridge_read(ADDR_GEN_COUNT, data);
        check_value(data, 32'd0, "generation count after reset");
        compare_board("reset");

        // seed write, readback and load
        for (int r = 0; r < GRID_H; r++) begin
            for (int w = 0; w < 2; w++) begin
                bridge_write(SEED_BASE + 32'(r * 8 + w * 4), seed_words[r][w]);
            end
        end
        for (int r = 0; r < GRID_H; r++) begin
            for (int w = 0; w < 2; w++) begin
                bridge_read(SEED_BASE + 32'(r * 8 + w * 4), data);
                check_value(data, seed_words[r][w],
                            $sformatf("seed readback row %0d word %0d", r, w));
            end
        end
        bridge_write(ADDR_CTRL, 32'(1) << CTRL_LOAD);
        model_from_seed();
        compare_board("load");
        bridge_read(ADDR_GEN_COUNT, data);
        check_value(data, 32'd0, "generation count after load");

        // single steps with run clear
        count_before = int'(data[15:0]);
        for (int i = 0; i < step_count; i++) begin
            bridge_write(ADDR_CTRL, 32'(1) << CTRL_STEP);
        end
        bridge_read(ADDR_GEN_COUNT, data);
        check_value(data, 32'(count_before + step_count), "generation count after steps");
        advance_model(step_count);
        compare_board("step");

        // free run until the count reaches the file minimum
        count_before = int'(data[15:0]);
        bridge_write(ADDR_GEN_SPEED, 32'(run_speed));
        bridge_read(ADDR_GEN_SPEED, data);
        check_value(data, 32'(run_speed), "speed readback");
        bridge_write(ADDR_CTRL, 32'(1) << CTRL_RUN);
        polls       = 0;
        count_after = count_before;
        while (count_after < run_min) begin
            if (polls == POLL_LIMIT) begin
                stop_on_error("generation count did not reach the run minimum in time");
            end
            bridge_read(ADDR_GEN_COUNT, data);
            count_after = int'(data[15:0]);
            polls++;
        end
        bridge_write(ADDR_CTRL, 32'd0);
        bridge_read(ADDR_GEN_COUNT, data);
        count_after = int'(data[15:0]);
        advance_model(count_after - count_before);
        compare_board("run");

        check_frame();

        $display("NO ERRORS");
        $finish;
    end

endmodule

/* filelist.f */
common/life_pkg.sv
life/life_cell.sv
life/life_board.sv
life/gen_ticker.sv
video/video_timing.sv
video/pixel_renderer.sv
design/bridge_regs.sv
design/life_top.sv
verification/life_tb.sv

/* Makefile */
# Verilator build and run of the life core testbench
# run from the project root so the stimulus file path resolves

VERILATOR ?= verilator
TOP       ?= life_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# the simulation binary exits non-zero on $fatal
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* verification/life_stimulus.txt */
# seed <row> <word> <hex value> : one seed word, words not listed are zero
# steps <count> : step writes | run <speed> <minimum generation count>
# glider across the bottom and right wrap edges
seed 47 0 00000001
seed 0 0 00000002
seed 1 0 00000003
seed 1 1 80000000
# blinker across the left and right edges
seed 20 0 00000003
seed 20 1 80000000
# r-pentomino in the upper left quarter
seed 10 0 00600000
seed 11 0 00300000
seed 12 0 00200000
# still block
seed 30 1 00000300
seed 31 1 00000300
# step phase then run phase at a period of eight cycles
steps 9
run 3125000 40
